/* Makefile */
VERILATOR  ?= verilator
VFLAGS     = --timing --assert --timescale 1ns/100ps
TOP        = tb_ex_stage
FILELIST   = src.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAILED" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/ex_alu.sv */
// Combinational ALU whose shifts use only the low five bits of operand b
`default_nettype none

module ex_alu
  import ex_pkg::*;
(
  ex_op_if.alu  op_i,
  ex_res_if.alu res_o
);

  logic               sub_sel;
  logic [XLEN-1:0]    b_inv;
  logic [XLEN:0]      sum_ext;
  logic               eq;
  logic               lt_s;
  logic               lt_u;
  logic               cmp;
  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    result;

  // Shared adder for add, sub and every compare
  assign sub_sel = (op_i.alu_op != ALU_ADD);
  assign b_inv   = sub_sel ? ~op_i.operand_b : op_i.operand_b;
  assign sum_ext = {1'b0, op_i.operand_a} + {1'b0, b_inv} + {{XLEN{1'b0}}, sub_sel};

  // Carry out of a - b is set when a >= b unsigned
  assign lt_u = ~sum_ext[XLEN];
  // Signs differ so a negative a is the smaller one
  assign lt_s = (op_i.operand_a[XLEN-1] != op_i.operand_b[XLEN-1]) ?
                op_i.operand_a[XLEN-1] : sum_ext[XLEN-1];
  assign eq   = ~|(op_i.operand_a ^ op_i.operand_b);

  // Compare flag shared by slt, sltu and branches
  always_comb begin
    unique case (op_i.alu_op)
      ALU_EQ:            cmp = eq;
      ALU_NE:            cmp = ~eq;
      ALU_LT, ALU_SLT:   cmp = lt_s;
      ALU_GE:            cmp = ~lt_s;
      ALU_LTU, ALU_SLTU: cmp = lt_u;
      ALU_GEU:           cmp = ~lt_u;
      default:           cmp = 1'b0;
    endcase
  end

  assign shamt = op_i.operand_b[SHAMT_W-1:0];

  always_comb begin
    unique case (op_i.alu_op)
      ALU_ADD, ALU_SUB: result = sum_ext[XLEN-1:0];
      ALU_AND:          result = op_i.operand_a & op_i.operand_b;
      ALU_OR:           result = op_i.operand_a | op_i.operand_b;
      ALU_XOR:          result = op_i.operand_a ^ op_i.operand_b;
      ALU_SLL:          result = op_i.operand_a << shamt;
      ALU_SRL:          result = op_i.operand_a >> shamt;
      ALU_SRA:          result = $signed(op_i.operand_a) >>> shamt;
      // slt, sltu and branch compares return the flag zero extended
      default:          result = {{(XLEN-1){1'b0}}, cmp};
    endcase
  end

  assign res_o.alu_result = result;
  assign res_o.cmp_result = cmp;

endmodule

`default_nettype wire

/* hdl/ex_decode.sv */
// Purely combinational and unknown opcodes decode as nop with no unit enabled
`default_nettype none

module ex_decode
  import ex_pkg::*;
(
  input  logic              op_valid_i,
  input  ex_opcode_e        op_i,
  input  logic [XLEN-1:0]   operand_a_i,
  input  logic [XLEN-1:0]   operand_b_i,
  input  logic [REG_AW-1:0] rd_i,
  ex_op_if.decode           op_o
);

  logic    is_arith;
  logic    is_cmp;
  logic    is_mul;
  logic    is_load;
  alu_op_e alu_op;
  mul_op_e mul_op;

  // Operation class
  assign is_arith = op_i inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL,
                                 OP_SRA, OP_SLT, OP_SLTU};
  assign is_cmp   = op_i inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
  assign is_mul   = op_i inside {OP_MUL, OP_MULH, OP_MULHU};
  assign is_load  = (op_i == OP_LOAD);

  // Branches reuse the ALU comparator
  always_comb begin
    alu_op = ALU_ADD;
    mul_op = MUL_MUL;
    unique case (op_i)
      OP_SUB:   alu_op = ALU_SUB;
      OP_AND:   alu_op = ALU_AND;
      OP_OR:    alu_op = ALU_OR;
      OP_XOR:   alu_op = ALU_XOR;
      OP_SLL:   alu_op = ALU_SLL;
      OP_SRL:   alu_op = ALU_SRL;
      OP_SRA:   alu_op = ALU_SRA;
      OP_SLT:   alu_op = ALU_SLT;
      OP_SLTU:  alu_op = ALU_SLTU;
      OP_BEQ:   alu_op = ALU_EQ;
      OP_BNE:   alu_op = ALU_NE;
      OP_BLT:   alu_op = ALU_LT;
      OP_BGE:   alu_op = ALU_GE;
      OP_BLTU:  alu_op = ALU_LTU;
      OP_BGEU:  alu_op = ALU_GEU;
      OP_MULH:  mul_op = MUL_MULH;
      OP_MULHU: mul_op = MUL_MULHU;
      default:  alu_op = ALU_ADD;
    endcase
  end

  // Enables only with a valid op
  assign op_o.alu_en    = op_valid_i & (is_arith | is_cmp);
  assign op_o.is_branch = op_valid_i & is_cmp;
  assign op_o.mult_en   = op_valid_i & is_mul;
  assign op_o.load_we   = op_valid_i & is_load;
  // Writes to register 0 are dropped here
  assign op_o.fw_we     = op_valid_i & (is_arith | is_mul) & (rd_i != '0);
  assign op_o.alu_op    = alu_op;
  assign op_o.mult_op   = mul_op;
  assign op_o.rd        = rd_i;
  assign op_o.operand_a = operand_a_i;
  assign op_o.operand_b = operand_b_i;

  // The result mux picks one unit and relies on at most one being enabled
  always_comb begin
    assert (!(op_o.alu_en && op_o.mult_en))
      else $error("ALU and multiplier enabled together");
  end

endmodule

`default_nettype wire

/* hdl/ex_if.sv */
// Internal buses of the execute stage and not meant for use at the top level
`default_nettype none

// Decoded operation, driven by ex_decode and read by every unit
interface ex_op_if
  import ex_pkg::*;
();

  // Unit enables, already qualified by op valid
  logic              alu_en;
  alu_op_e           alu_op;
  logic              mult_en;
  mul_op_e           mult_op;

  // Write controls, fw_we is already low for register 0
  logic              fw_we;
  logic              load_we;
  logic              is_branch;

  // Destination and source operands
  logic [REG_AW-1:0] rd;
  logic [XLEN-1:0]   operand_a;
  logic [XLEN-1:0]   operand_b;

  modport decode (
    output alu_en, alu_op, mult_en, mult_op,
    output fw_we, load_we, is_branch,
    output rd, operand_a, operand_b
  );

  modport alu (input alu_op, operand_a, operand_b);

  modport mult (input mult_en, mult_op, operand_a, operand_b);

  modport result (input alu_en, mult_en, fw_we, load_we, is_branch, rd);

endinterface

// Unit results collected by ex_result
interface ex_res_if
  import ex_pkg::*;
();

  logic [XLEN-1:0] alu_result;
  // Compare flag for slt, sltu and branches
  logic            cmp_result;
  logic [XLEN-1:0] mult_result;
  // Low while a high-product multiply is still in flight
  logic            mult_ready;

  modport alu (output alu_result, cmp_result);
  modport mult (output mult_result, mult_ready);
  modport result (input alu_result, cmp_result, mult_result, mult_ready);

endinterface

`default_nettype wire

/* hdl/ex_mult.sv */
// mulh and mulhu need the operands held stable until the stage accepts the op
`default_nettype none

module ex_mult
  import ex_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   ex_ready_i,
  ex_op_if.mult  op_i,
  ex_res_if.mult res_o,
  output logic   multicycle_o
);

  mult_state_e            state_q;
  mult_state_e            state_d;
  mult_state_e            cur_state;
  logic                   mulh_req;
  logic                   sgn;
  logic                   lo_en;
  logic                   hi_en;
  logic                   ready;
  logic signed [PP_W-1:0] a_lo;
  logic signed [PP_W-1:0] a_hi;
  logic signed [PP_W-1:0] b_lo;
  logic signed [PP_W-1:0] b_hi;
  logic signed [PP_W-1:0] pp_ll_q;
  logic signed [PP_W-1:0] pp_lh_q;
  logic signed [PP_W-1:0] pp_hl_q;
  logic signed [PP_W-1:0] pp_hh_q;
  logic [XLEN-1:0]        prod_lo;
  logic [2*XLEN-1:0]      mulh_sum;

  // mul finishes in the cycle it arrives
  assign prod_lo = op_i.operand_a * op_i.operand_b;

  // Halves as signed pieces with the upper half sign extended only for mulh
  assign sgn  = (op_i.mult_op == MUL_MULH);
  assign a_lo = {{(PP_W-HALF_W){1'b0}}, op_i.operand_a[HALF_W-1:0]};
  assign b_lo = {{(PP_W-HALF_W){1'b0}}, op_i.operand_b[HALF_W-1:0]};
  assign a_hi = {{(PP_W-HALF_W){sgn & op_i.operand_a[XLEN-1]}}, op_i.operand_a[XLEN-1:HALF_W]};
  assign b_hi = {{(PP_W-HALF_W){sgn & op_i.operand_b[XLEN-1]}}, op_i.operand_b[XLEN-1:HALF_W]};

  ////////////////////////////////////////
  // High-product sequence
  ////////////////////////////////////////

  assign mulh_req = op_i.mult_en & (op_i.mult_op != MUL_MUL);

  // A new mulh in idle already does the low step in its first cycle
  always_comb begin
    cur_state = state_q;
    if ((state_q == MS_IDLE) && mulh_req) begin
      cur_state = MS_LOW_PP;
    end
  end

  always_comb begin
    state_d = cur_state;
    ready   = 1'b1;
    lo_en   = 1'b0;
    hi_en   = 1'b0;
    unique case (cur_state)
      MS_IDLE: state_d = MS_IDLE;
      MS_LOW_PP: begin
        ready   = 1'b0;
        lo_en   = 1'b1;
        state_d = MS_HIGH_PP;
      end
      MS_HIGH_PP: begin
        ready   = 1'b0;
        hi_en   = 1'b1;
        state_d = MS_DONE;
      end
      // Result held until the stage takes the op
      MS_DONE: if (ex_ready_i) state_d = MS_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Partial products against the low half of a and then the high half
  always_ff @(posedge clk) begin
    if (lo_en) begin
      pp_ll_q <= a_lo * b_lo;
      pp_lh_q <= a_lo * b_hi;
    end
    if (hi_en) begin
      pp_hl_q <= a_hi * b_lo;
      pp_hh_q <= a_hi * b_hi;
    end
  end

  // Sum in 64-bit modular arithmetic
  assign mulh_sum = ({{(2*XLEN-PP_W){pp_hh_q[PP_W-1]}}, pp_hh_q} << XLEN)
                  + (({{(2*XLEN-PP_W){pp_hl_q[PP_W-1]}}, pp_hl_q}
                    + {{(2*XLEN-PP_W){pp_lh_q[PP_W-1]}}, pp_lh_q}) << HALF_W)
                  + {{(2*XLEN-PP_W){pp_ll_q[PP_W-1]}}, pp_ll_q};

  assign res_o.mult_result = (op_i.mult_op == MUL_MUL) ? prod_lo : mulh_sum[2*XLEN-1:XLEN];
  assign res_o.mult_ready  = ready;
  assign multicycle_o      = (cur_state != MS_IDLE);

  // A high-product multiply frees the stage within its latency
  a_mult_ready_bound : assert property (@(posedge clk) disable iff (!rst_n)
    !res_o.mult_ready [*(MULH_CYCLES-1)] |=> res_o.mult_ready);

endmodule

`default_nettype wire

/* hdl/ex_pkg.sv */
// Fixed 32-bit datapath with 5-bit register addresses and no module parameters
`default_nettype none

package ex_pkg;

  // Datapath and register file sizes
  localparam int unsigned XLEN    = 32;
  localparam int unsigned REG_AW  = 5;
  localparam int unsigned SHAMT_W = $clog2(XLEN);

  // Multiplier split into 16-bit halves, each piece sign extended to 34 bits
  localparam int unsigned HALF_W = XLEN / 2;
  localparam int unsigned PP_W   = 2 * HALF_W + 2;

  // Cycles a mulh or mulhu holds the stage, acceptance cycle included
  localparam int unsigned MULH_CYCLES = 3;

  // External opcode as it arrives from decode
  typedef enum logic [4:0] {
    OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL,
    OP_SRA, OP_SLT, OP_SLTU, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU,
    OP_BGEU, OP_MUL, OP_MULH, OP_MULHU, OP_LOAD
  } ex_opcode_e;

  // ALU opcode, arithmetic and logic first, then the branch compares
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL,
    ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Multiplier opcode
  typedef enum logic [1:0] {
    MUL_MUL, MUL_MULH, MUL_MULHU
  } mul_op_e;

  // High-product multiplier sequence
  typedef enum logic [1:0] {
    MS_IDLE, MS_LOW_PP, MS_HIGH_PP, MS_DONE
  } mult_state_e;

endpackage

`default_nettype wire

/* hdl/ex_result.sv */
// Load data is taken from the LSU in the writeback cycle and is not registered
`default_nettype none

module ex_result
  import ex_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              op_valid_i,
  input  logic              wb_ready_i,
  input  logic [XLEN-1:0]   operand_c_i,
  input  logic [XLEN-1:0]   lsu_rdata_i,
  ex_op_if.result           op_i,
  ex_res_if.result          res_i,
  output logic              ex_ready_o,
  output logic              ex_valid_o,
  output logic              fw_we_o,
  output logic [REG_AW-1:0] fw_waddr_o,
  output logic [XLEN-1:0]   fw_wdata_o,
  output logic              wb_we_o,
  output logic [REG_AW-1:0] wb_waddr_o,
  output logic [XLEN-1:0]   wb_wdata_o,
  output logic              branch_decision_o,
  output logic [XLEN-1:0]   jump_target_o
);

  logic              has_result;
  logic              wr_accept;
  logic              wb_we_q;
  logic [REG_AW-1:0] wb_waddr_q;

  ////////////////////////////////////////
  // Forward port
  ////////////////////////////////////////

  // Multiplier wins when enabled, else the ALU
  always_comb begin
    fw_we_o    = op_i.fw_we;
    fw_waddr_o = op_i.rd;
    fw_wdata_o = res_i.alu_result;
    if (op_i.mult_en) begin
      fw_wdata_o = res_i.mult_result;
    end
  end

  // Branch outcome goes to fetch directly
  assign branch_decision_o = op_i.is_branch & res_i.cmp_result;
  assign jump_target_o     = operand_c_i;

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  // Ops that produce a register write
  assign has_result = (op_i.alu_en & ~op_i.is_branch) | op_i.mult_en | op_i.load_we;

  // Branches finish here so they skip writeback back-pressure
  assign ex_ready_o = (res_i.mult_ready & wb_ready_i) | op_i.is_branch;
  // Valid flows right and ready left, so no ex_ready_o term here
  assign ex_valid_o = has_result & res_i.mult_ready & wb_ready_i;

  // Accepted non-branch op, writeback is ready whenever this is high
  assign wr_accept = op_valid_i & ex_ready_o & ~op_i.is_branch;

  ////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q <= 1'b0;
    end else if (wr_accept) begin
      wb_we_q <= op_i.load_we;
    end else if (wb_ready_i) begin
      // Writeback drained and nothing new arrived
      wb_we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept && op_i.load_we) begin
      wb_waddr_q <= op_i.rd;
    end
  end

  assign wb_we_o    = wb_we_q;
  assign wb_waddr_o = wb_waddr_q;
  assign wb_wdata_o = lsu_rdata_i;

  // A load writeback only ever starts right after a load was accepted
  a_wb_we_origin : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wb_we_o) |-> $past(op_valid_i && ex_ready_o && op_i.load_we));

endmodule

`default_nettype wire

/* hdl/ex_stage.sv */
// Top level holds one op per cycle and expects op inputs held while ex_ready_o is low
`default_nettype none

module ex_stage
  import ex_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  // Decode side
  input  logic              op_valid_i,
  input  ex_opcode_e        op_i,
  input  logic [XLEN-1:0]   operand_a_i,
  input  logic [XLEN-1:0]   operand_b_i,
  input  logic [XLEN-1:0]   operand_c_i,
  input  logic [REG_AW-1:0] rd_i,
  output logic              ex_ready_o,

  // LSU and writeback
  input  logic [XLEN-1:0]   lsu_rdata_i,
  input  logic              wb_ready_i,

  // Forward write port, ALU and multiplier
  output logic              fw_we_o,
  output logic [REG_AW-1:0] fw_waddr_o,
  output logic [XLEN-1:0]   fw_wdata_o,

  // Load write port
  output logic              wb_we_o,
  output logic [REG_AW-1:0] wb_waddr_o,
  output logic [XLEN-1:0]   wb_wdata_o,

  // To fetch
  output logic              branch_decision_o,
  output logic [XLEN-1:0]   jump_target_o,

  output logic              ex_valid_o,
  output logic              mult_multicycle_o
);

  ////////////////////////////////////////
  // Internal buses
  ////////////////////////////////////////

  ex_op_if  op_bus ();
  ex_res_if res_bus ();

  ex_decode u_decode (
    .op_valid_i  (op_valid_i),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .rd_i        (rd_i),
    .op_o        (op_bus.decode)
  );

  ex_alu u_alu (
    .op_i  (op_bus.alu),
    .res_o (res_bus.alu)
  );

  // Stage ready closes the multiplier done state
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_ready_i   (ex_ready_o),
    .op_i         (op_bus.mult),
    .res_o        (res_bus.mult),
    .multicycle_o (mult_multicycle_o)
  );

  ex_result u_result (
    .clk               (clk),
    .rst_n             (rst_n),
    .op_valid_i        (op_valid_i),
    .wb_ready_i        (wb_ready_i),
    .operand_c_i       (operand_c_i),
    .lsu_rdata_i       (lsu_rdata_i),
    .op_i              (op_bus.result),
    .res_i             (res_bus.result),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o),
    .fw_we_o           (fw_we_o),
    .fw_waddr_o        (fw_waddr_o),
    .fw_wdata_o        (fw_wdata_o),
    .wb_we_o           (wb_we_o),
    .wb_waddr_o        (wb_waddr_o),
    .wb_wdata_o        (wb_wdata_o),
    .branch_decision_o (branch_decision_o),
    .jump_target_o     (jump_target_o)
  );

endmodule

`default_nettype wire

/* src.f */
+incdir+test
hdl/ex_pkg.sv
hdl/ex_if.sv
hdl/ex_decode.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_result.sv
hdl/ex_stage.sv
test/tb_ex_stage.sv

/* test/tb_ex_model.svh */
// Model of the execute rules for the fixed 32-bit datapath and included inside tb_ex_stage only
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// Register result of an ALU or multiply op
function automatic logic [31:0] model_result(input ex_opcode_e op, input logic [31:0] a,
                                             input logic [31:0] b);
  logic [63:0] uprod;
  logic [63:0] sprod;
  logic [31:0] r;
  uprod = {32'b0, a} * {32'b0, b};
  // Sign extended to 64 bits, low 64 bits of the product stay exact
  sprod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
  case (op)
    OP_ADD:   r = a + b;
    OP_SUB:   r = a - b;
    OP_AND:   r = a & b;
    OP_OR:    r = a | b;
    OP_XOR:   r = a ^ b;
    // Shift amount from the low five bits
    OP_SLL:   r = a << b[4:0];
    OP_SRL:   r = a >> b[4:0];
    OP_SRA:   r = $signed(a) >>> b[4:0];
    OP_SLT:   r = {31'b0, $signed(a) < $signed(b)};
    OP_SLTU:  r = {31'b0, a < b};
    OP_MUL:   r = uprod[31:0];
    OP_MULH:  r = sprod[63:32];
    OP_MULHU: r = uprod[63:32];
    default:  r = 32'b0;
  endcase
  return r;
endfunction

// Taken flag of a branch compare
function automatic logic model_branch(input ex_opcode_e op, input logic [31:0] a,
                                      input logic [31:0] b);
  logic taken;
  case (op)
    OP_BEQ:  taken = (a == b);
    OP_BNE:  taken = (a != b);
    OP_BLT:  taken = ($signed(a) < $signed(b));
    OP_BGE:  taken = ($signed(a) >= $signed(b));
    OP_BLTU: taken = (a < b);
    OP_BGEU: taken = (a >= b);
    default: taken = 1'b0;
  endcase
  return taken;
endfunction

`endif

/* test/tb_ex_stage.sv */
// Fixed-seed random test where writeback ready is held high through each mulh and mulhu stall
`default_nettype none

module tb_ex_stage
  import ex_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 16;
  localparam int DRIVE_DELAY   = 1;
  localparam int NUM_OPS       = 400;
  localparam int OP_TIMEOUT    = 64;
  localparam int DRAIN_TIMEOUT = 64;
  localparam int SIM_LIMIT_NS  = 100000;

  logic              clk;
  logic              rst_n;
  logic              op_valid_i;
  ex_opcode_e        op_i;
  logic [XLEN-1:0]   operand_a_i;
  logic [XLEN-1:0]   operand_b_i;
  logic [XLEN-1:0]   operand_c_i;
  logic [REG_AW-1:0] rd_i;
  logic              ex_ready_o;
  logic [XLEN-1:0]   lsu_rdata_i;
  logic              wb_ready_i;
  logic              fw_we_o;
  logic [REG_AW-1:0] fw_waddr_o;
  logic [XLEN-1:0]   fw_wdata_o;
  logic              wb_we_o;
  logic [REG_AW-1:0] wb_waddr_o;
  logic [XLEN-1:0]   wb_wdata_o;
  logic              branch_decision_o;
  logic [XLEN-1:0]   jump_target_o;
  logic              ex_valid_o;
  logic              mult_multicycle_o;

  int                seed;
  int                errors;
  int                checks;
  int                timeouts;
  // Destinations of accepted loads still waiting for writeback
  logic [REG_AW-1:0] load_q[$];
  bit                load_due;
  logic [REG_AW-1:0] load_due_rd;

  `include "tb_ex_model.svh"

  ex_stage DUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Last resort against a stuck run
  initial begin
    #(SIM_LIMIT_NS);
    $display("Simulation time limit reached before the test ended");
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // Checks and op classes
  ////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      $display("[FAIL] %s expected %h actual %h at %0t", name, expected, actual, $time);
      errors++;
    end
  endtask

  function automatic bit is_branch_op(input ex_opcode_e op);
    return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
  endfunction

  // Ops that write through the forward port
  function automatic bit writes_fw(input ex_opcode_e op);
    return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA,
                      OP_SLT, OP_SLTU, OP_MUL, OP_MULH, OP_MULHU};
  endfunction

  // Load port sampled once per cycle
  task automatic check_wb_port();
    logic [REG_AW-1:0] exp_rd;
    // Write must show up exactly one cycle after the load
    if (load_due) begin
      check_val("load wb_we", 1, 32'(wb_we_o));
      check_val("load wb_waddr", 32'(load_due_rd), 32'(wb_waddr_o));
      check_val("load wb_wdata", lsu_rdata_i, wb_wdata_o);
      load_due = 1'b0;
    end
    // Committed writebacks in load order
    if (wb_we_o && wb_ready_i) begin
      if (load_q.size() == 0) begin
        $display("Load writeback with no pending load at %0t", $time);
        errors++;
      end else begin
        exp_rd = load_q.pop_front();
        check_val("wb order waddr", 32'(exp_rd), 32'(wb_waddr_o));
        check_val("wb wdata", lsu_rdata_i, wb_wdata_o);
      end
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic idle_cycle();
    op_valid_i  = 1'b0;
    lsu_rdata_i = $random(seed);
    wb_ready_i  = (($random(seed) & 3) != 0);
    @(negedge clk);
    check_wb_port();
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  // Holds one op until it is accepted and checks it in that cycle
  task automatic run_op(input ex_opcode_e opc, input logic [31:0] a, input logic [31:0] b,
                        input logic [31:0] c, input logic [REG_AW-1:0] rd);
    int    waited;
    bit    accepted;
    bit    is_mulh;
    bit    exp_fw;
    string tag;
    tag         = opc.name();
    is_mulh     = (opc == OP_MULH) || (opc == OP_MULHU);
    exp_fw      = writes_fw(opc) && (rd != '0);
    waited      = 0;
    accepted    = 1'b0;
    op_valid_i  = 1'b1;
    op_i        = opc;
    operand_a_i = a;
    operand_b_i = b;
    operand_c_i = c;
    rd_i        = rd;
    while (!accepted && timeouts == 0) begin
      lsu_rdata_i = $random(seed);
      // Writeback stays ready through a mulh stall so its length is exact
      if (is_mulh && waited < MULH_CYCLES - 1) begin
        wb_ready_i = 1'b1;
      end else begin
        wb_ready_i = (($random(seed) & 3) != 0);
      end
      @(negedge clk);
      check_wb_port();
      // A mulh stalls a fixed number of cycles and then waits only on writeback
      if (is_mulh) begin
        check_val({tag, " ready"}, 32'(waited >= MULH_CYCLES - 1 && wb_ready_i),
                  32'(ex_ready_o));
      end
      if (ex_ready_o) begin
        accepted = 1'b1;
        check_val({tag, " ex_valid"}, 32'(opc != OP_NOP && !is_branch_op(opc)),
                  32'(ex_valid_o));
        check_val({tag, " fw_we"}, 32'(exp_fw), 32'(fw_we_o));
        if (exp_fw) begin
          check_val({tag, " fw_waddr"}, 32'(rd), 32'(fw_waddr_o));
          check_val({tag, " fw_wdata"}, model_result(opc, a, b), fw_wdata_o);
        end
        // Branches never wait on writeback
        if (is_branch_op(opc)) begin
          check_val({tag, " decision"}, 32'(model_branch(opc, a, b)),
                    32'(branch_decision_o));
          check_val({tag, " target"}, c, jump_target_o);
          check_val({tag, " stall"}, 0, waited);
        end
        if (opc == OP_LOAD) begin
          load_q.push_back(rd);
          load_due    = 1'b1;
          load_due_rd = rd;
        end
      end else begin
        if (is_mulh && waited < MULH_CYCLES - 1) begin
          check_val({tag, " multicycle"}, 1, 32'(mult_multicycle_o));
        end
        waited++;
        if (waited > OP_TIMEOUT) begin
          $display("Timeout: %s not accepted after %0d cycles", tag, waited);
          timeouts++;
        end
      end
      @(posedge clk);
      #(DRIVE_DELAY);
    end
    op_valid_i = 1'b0;
  endtask

  // Lets every pending load reach writeback
  task automatic drain_loads();
    int waited;
    waited     = 0;
    op_valid_i = 1'b0;
    while ((load_q.size() != 0 || load_due) && timeouts == 0) begin
      lsu_rdata_i = $random(seed);
      wb_ready_i  = (($random(seed) & 3) != 0);
      @(negedge clk);
      check_wb_port();
      @(posedge clk);
      #(DRIVE_DELAY);
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        $display("Timeout waiting for %0d pending load writebacks", load_q.size());
        timeouts++;
      end
    end
    // No writeback left over once every load is done
    @(negedge clk);
    check_val("wb idle after drain", 0, 32'(wb_we_o));
  endtask

  initial begin
    int unsigned pick;
    ex_opcode_e  opc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] r;
    seed        = 32'h49e6;
    errors      = 0;
    checks      = 0;
    timeouts    = 0;
    load_due    = 1'b0;
    load_due_rd = '0;
    rst_n       = 1'b0;
    op_valid_i  = 1'b0;
    op_i        = OP_NOP;
    operand_a_i = '0;
    operand_b_i = '0;
    operand_c_i = '0;
    rd_i        = '0;
    lsu_rdata_i = '0;
    wb_ready_i  = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;
    // Outputs idle before any op
    @(negedge clk);
    check_val("reset wb_we", 0, 32'(wb_we_o));
    check_val("reset ex_valid", 0, 32'(ex_valid_o));
    check_val("reset multicycle", 0, 32'(mult_multicycle_o));
    @(posedge clk);
    #(DRIVE_DELAY);
    for (int i = 0; i < NUM_OPS && timeouts == 0; i++) begin
      if (($random(seed) & 3) == 0) begin
        idle_cycle();
      end
      pick = $unsigned($random(seed)) % 21;
      opc  = ex_opcode_e'(pick[4:0]);
      a    = $random(seed);
      b    = $random(seed);
      // Equal operands now and then for beq and bne
      if (b[2:0] == 3'd0) begin
        b = a;
      end
      c = $random(seed);
      r = $random(seed);
      run_op(opc, a, b, c, r[REG_AW-1:0]);
    end
    drain_loads();
    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
